/* rtl/cnn_tile_pkg.sv */
package cnn_tile_pkg;

    // output tile geometry
    localparam int TN = 4;  // output channels per tile
    localparam int TR = 4;  // rows per tile
    localparam int TC = 4;  // columns per tile

    // channels are split evenly over the banks
    localparam int Y_BANKS = 2;

    // words held by one bank
    localparam int BANK_DEPTH = (TN / Y_BANKS) * TR * TC;

    // whole tile, walked bank-major by the outer streams
    localparam int TILE_WORDS = BANK_DEPTH * Y_BANKS;

endpackage

/* rtl/ofm_data_pkg.sv */
package ofm_data_pkg;
    import cnn_tile_pkg::*;

    localparam int DW = 32;  // psum / result word

    // address and bank select widths, at least one bit each
    localparam int AW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;
    localparam int BSW = (Y_BANKS > 1) ? $clog2(Y_BANKS) : 1;

    typedef logic [DW-1:0] ofm_word_t;
    typedef logic [AW-1:0] ofm_addr_t;

    // accept cycle to bank write cycle
    localparam int ACC_LATENCY = 2;

endpackage

/* rtl/seq_counter.sv */
`timescale 1ns/100ps

module seq_counter #(
    parameter int CW = 8,   // counter width
    parameter int MAX = 16  // counts 0 .. MAX-1
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ena,
    output logic [CW-1:0] cnt,
    output logic          wrap
);

    logic at_last;  // sitting on MAX-1

    assign at_last = (cnt == CW'(MAX - 1));
    assign wrap = ena & at_last;  // one pulse per full pass

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (ena) begin
            if (at_last)
                cnt <= '0;          // back to the first word
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

/* rtl/dp_ram.sv */
`timescale 1ns/100ps

module dp_ram
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
(
    input  logic      clk,
    input  logic      wr_ena,
    input  ofm_addr_t wr_addr,
    input  ofm_word_t wr_data,
    input  ofm_addr_t rd_addr,
    output ofm_word_t rd_data
);

    // one bank worth of words, contents undefined until loaded
    ofm_word_t mem [BANK_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_ena)
            mem[wr_addr] <= wr_data;
    end

    // registered read, same-address collision gives the old word
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/output_fm_bank.sv */
`timescale 1ns/100ps

module output_fm_bank
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    // outer load side
    input  logic      wr_ena,
    input  ofm_word_t wr_data,

    // outer store side
    input  logic      rd_ena,
    output ofm_word_t rd_data,

    input  logic      computing_on_going,  // inner side owns the ram

    // inner accumulator side
    input  ofm_addr_t inter_rd_addr,
    output ofm_word_t inter_rd_data,
    input  logic      inter_wr_ena,
    input  ofm_addr_t inter_wr_addr,
    input  ofm_word_t inter_wr_data
);

    logic      ld_ena_q;   // load strobe, delayed one cycle
    ofm_word_t ld_data_q;  // load word, delayed one cycle
    ofm_addr_t ld_addr;    // next load address
    ofm_addr_t st_addr;    // next store address
    logic      ram_wr_ena;
    ofm_addr_t ram_wr_addr;
    ofm_word_t ram_wr_data;
    ofm_addr_t ram_rd_addr;
    ofm_word_t ram_rd_data;

    // load register, the write lands one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ld_ena_q <= 1'b0;
        else
            ld_ena_q <= wr_ena;
    end

    always_ff @(posedge clk) begin
        ld_data_q <= wr_data;  // payload only
    end

    // load address steps with the actual write
    seq_counter #(
        .CW  (AW),
        .MAX (BANK_DEPTH)
    ) u_ld_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ld_ena_q),
        .cnt   (ld_addr),
        .wrap  ()
    );

    // store address is presented in the strobe cycle
    seq_counter #(
        .CW  (AW),
        .MAX (BANK_DEPTH)
    ) u_st_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (rd_ena),
        .cnt   (st_addr),
        .wrap  ()
    );

    // port ownership
    assign ram_wr_ena  = computing_on_going ? inter_wr_ena  : ld_ena_q;
    assign ram_wr_addr = computing_on_going ? inter_wr_addr : ld_addr;
    assign ram_wr_data = computing_on_going ? inter_wr_data : ld_data_q;
    assign ram_rd_addr = computing_on_going ? inter_rd_addr : st_addr;

    dp_ram u_ram (
        .clk     (clk),
        .wr_ena  (ram_wr_ena),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    // both sides see the same read word
    assign rd_data       = ram_rd_data;
    assign inter_rd_data = ram_rd_data;

endmodule

/* rtl/ofm_stream_ctrl.sv */
`timescale 1ns/100ps

module ofm_stream_ctrl
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      ld_ena,
    input  ofm_word_t                 ld_data,

    input  logic                      st_ena,
    output ofm_word_t                 st_data,
    output logic                      st_valid,

    output logic      [Y_BANKS-1:0]   bank_wr_ena,
    output ofm_word_t                 bank_wr_data,
    output logic      [Y_BANKS-1:0]   bank_rd_ena,
    input  ofm_word_t [Y_BANKS-1:0]   bank_rd_data
);

    logic           ld_word_wrap;  // last word of the current load bank
    logic           st_word_wrap;  // last word of the current store bank
    logic [BSW-1:0] ld_sel;        // bank taking loads
    logic [BSW-1:0] st_sel;        // bank serving stores
    logic [BSW-1:0] st_sel_q;      // bank whose read data returns now

    // load position, word within bank then bank
    seq_counter #(.CW(AW), .MAX(BANK_DEPTH)) u_ld_word (
        .clk (clk), .rst_n (rst_n), .ena (ld_ena), .cnt (), .wrap (ld_word_wrap)
    );

    seq_counter #(.CW(BSW), .MAX(Y_BANKS)) u_ld_bank (
        .clk (clk), .rst_n (rst_n), .ena (ld_word_wrap), .cnt (ld_sel), .wrap ()
    );

    // store position, same bank-major order
    seq_counter #(.CW(AW), .MAX(BANK_DEPTH)) u_st_word (
        .clk (clk), .rst_n (rst_n), .ena (st_ena), .cnt (), .wrap (st_word_wrap)
    );

    seq_counter #(.CW(BSW), .MAX(Y_BANKS)) u_st_bank (
        .clk (clk), .rst_n (rst_n), .ena (st_word_wrap), .cnt (st_sel), .wrap ()
    );

    // strobe steering, one bank at a time
    always_comb begin
        for (int b = 0; b < Y_BANKS; b++) begin
            bank_wr_ena[b] = ld_ena & (ld_sel == BSW'(b));
            bank_rd_ena[b] = st_ena & (st_sel == BSW'(b));
        end
    end

    assign bank_wr_data = ld_data;  // every bank sees it, only one is strobed

    // read data comes back one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
            st_sel_q <= '0;
        end else begin
            st_valid <= st_ena;
            st_sel_q <= st_sel;
        end
    end

    assign st_data = bank_rd_data[st_sel_q];

endmodule

/* rtl/psum_accumulator.sv */
`timescale 1ns/100ps

module psum_accumulator
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    computing_on_going,

    // partial sum input, lane b for bank b
    input  logic                    psum_valid,
    input  ofm_addr_t               psum_addr,
    input  ofm_word_t [Y_BANKS-1:0] psum_data,

    // bank read, shared address
    output ofm_addr_t               rd_addr,
    input  ofm_word_t [Y_BANKS-1:0] rd_data,

    // bank write, shared address and enable
    output logic                    wr_ena,
    output ofm_addr_t               wr_addr,
    output ofm_word_t [Y_BANKS-1:0] wr_data
);

    logic                    accept;    // item taken this cycle
    logic                    s1_vld;    // stage one, waiting for ram data
    ofm_addr_t               s1_addr;
    ofm_word_t [Y_BANKS-1:0] s1_psum;
    logic                    hit_wr;    // same address one stage ahead
    logic                    hit_last;  // same address written last cycle
    ofm_word_t [Y_BANKS-1:0] base;      // old word, ram or forwarded
    ofm_word_t [Y_BANKS-1:0] sum;
    logic                    last_vld;  // write that just committed
    ofm_addr_t               last_addr;
    ofm_word_t [Y_BANKS-1:0] last_data;

    assign accept  = psum_valid & computing_on_going;
    assign rd_addr = psum_addr;  // read goes out in the accept cycle

    // stage one holds address and lanes while the ram answers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_vld <= 1'b0;
        else
            s1_vld <= accept;
    end

    always_ff @(posedge clk) begin
        s1_addr <= psum_addr;
        s1_psum <= psum_data;
    end

    // ram data is stale when an older sum to the same address is in flight
    assign hit_wr   = wr_ena & (wr_addr == s1_addr);      // not yet written
    assign hit_last = last_vld & (last_addr == s1_addr);  // written during the read

    always_comb begin
        if (hit_wr)
            base = wr_data;         // newest copy first
        else if (hit_last)
            base = last_data;
        else
            base = rd_data;
        for (int b = 0; b < Y_BANKS; b++)
            sum[b] = base[b] + s1_psum[b];  // wraps mod 2^DW
    end

    // stage two, registered write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ena   <= 1'b0;
            last_vld <= 1'b0;
        end else begin
            wr_ena   <= s1_vld;
            last_vld <= wr_ena;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr   <= s1_addr;
        wr_data   <= sum;
        last_addr <= wr_addr;  // mirrors the word the ram holds from now on
        last_data <= wr_data;
    end

endmodule

/* rtl/output_fm_buffer.sv */
`timescale 1ns/100ps

module output_fm_buffer
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,

    // outer streams
    input  logic                    ld_ena,
    input  ofm_word_t               ld_data,
    input  logic                    st_ena,
    output ofm_word_t               st_data,
    output logic                    st_valid,

    // inner accumulate port
    input  logic                    computing_on_going,
    input  logic                    psum_valid,
    input  ofm_addr_t               psum_addr,
    input  ofm_word_t [Y_BANKS-1:0] psum_data
);

    logic      [Y_BANKS-1:0] bank_wr_ena;
    ofm_word_t               bank_wr_data;  // shared load word
    logic      [Y_BANKS-1:0] bank_rd_ena;
    ofm_word_t [Y_BANKS-1:0] bank_rd_data;
    ofm_addr_t               acc_rd_addr;
    ofm_word_t [Y_BANKS-1:0] acc_rd_data;
    logic                    acc_wr_ena;
    ofm_addr_t               acc_wr_addr;
    ofm_word_t [Y_BANKS-1:0] acc_wr_data;

    ofm_stream_ctrl u_stream (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_ena       (ld_ena),
        .ld_data      (ld_data),
        .st_ena       (st_ena),
        .st_data      (st_data),
        .st_valid     (st_valid),
        .bank_wr_ena  (bank_wr_ena),
        .bank_wr_data (bank_wr_data),
        .bank_rd_ena  (bank_rd_ena),
        .bank_rd_data (bank_rd_data)
    );

    // one bank per channel group, own strobes and own data lane
    for (genvar b = 0; b < Y_BANKS; b++) begin : g_bank
        output_fm_bank u_bank (
            .clk                (clk),
            .rst_n              (rst_n),
            .wr_ena             (bank_wr_ena[b]),
            .wr_data            (bank_wr_data),
            .rd_ena             (bank_rd_ena[b]),
            .rd_data            (bank_rd_data[b]),
            .computing_on_going (computing_on_going),
            .inter_rd_addr      (acc_rd_addr),
            .inter_rd_data      (acc_rd_data[b]),
            .inter_wr_ena       (acc_wr_ena),
            .inter_wr_addr      (acc_wr_addr),
            .inter_wr_data      (acc_wr_data[b])
        );
    end

    psum_accumulator u_acc (
        .clk                (clk),
        .rst_n              (rst_n),
        .computing_on_going (computing_on_going),
        .psum_valid         (psum_valid),
        .psum_addr          (psum_addr),
        .psum_data          (psum_data),
        .rd_addr            (acc_rd_addr),
        .rd_data            (acc_rd_data),
        .wr_ena             (acc_wr_ena),
        .wr_addr            (acc_wr_addr),
        .wr_data            (acc_wr_data)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;  // released just after an edge
    end

endmodule

/* verification/output_fm_buffer_tb.sv */
`timescale 1ns/100ps

module output_fm_buffer_tb
    import cnn_tile_pkg::*;
    import ofm_data_pkg::*;
();

    localparam int PW = $clog2(TILE_WORDS);  // tile position width
    typedef logic [PW-1:0] pos_t;

    logic                    clk;
    logic                    rst_n;
    logic                    ld_ena;
    ofm_word_t               ld_data;
    logic                    st_ena;
    ofm_word_t               st_data;
    logic                    st_valid;
    logic                    computing_on_going;
    logic                    psum_valid;
    ofm_addr_t               psum_addr;
    ofm_word_t [Y_BANKS-1:0] psum_data;

    ofm_word_t   model [TILE_WORDS];  // expected tile, bank-major
    logic        known [TILE_WORDS];  // loaded at least once
    pos_t        ld_pos = '0;
    pos_t        st_pos = '0;         // store position, stepped at the edge
    logic        st_ena_q = 1'b0;
    logic        exp_chk = 1'b0;      // returning word has a known value
    ofm_word_t   exp_st = '0;
    int          st_issued = 0;
    int          st_returned = 0;
    int          n_checked = 0;
    logic [31:0] lfsr_state = 32'd85701;
    string       test_name = "reset";

    tb_clock_gen u_clk (.clk (clk), .rst_n (rst_n));

    output_fm_buffer DUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .ld_ena             (ld_ena),
        .ld_data            (ld_data),
        .st_ena             (st_ena),
        .st_data            (st_data),
        .st_valid           (st_valid),
        .computing_on_going (computing_on_going),
        .psum_valid         (psum_valid),
        .psum_addr          (psum_addr),
        .psum_data          (psum_data)
    );

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string what, ofm_word_t exp, ofm_word_t act);
        report_failure($sformatf("FAILED %s %s: expected %h actual %h",
                                 test_name, what, exp, act));
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] next_rand(int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // expected store word, picked in the strobe cycle
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_pos   <= '0;
            st_ena_q <= 1'b0;
            exp_chk  <= 1'b0;
        end else begin
            st_ena_q <= st_ena;
            exp_chk  <= st_ena & known[st_pos];
            exp_st   <= model[st_pos];
            if (st_ena)
                st_pos <= (st_pos == pos_t'(TILE_WORDS - 1)) ? '0 : st_pos + 1'b1;
            if (st_valid)
                st_returned <= st_returned + 1;
            if (st_valid && exp_chk)
                n_checked <= n_checked + 1;  // one data check done
        end
    end

    a_rst_valid: assert property (@(posedge clk) !rst_n |-> !st_valid)
        else report_mismatch("st_valid in reset", '0, ofm_word_t'($sampled(st_valid)));

    a_rst_acc: assert property (@(posedge clk) !rst_n |-> !DUT.acc_wr_ena)
        else report_mismatch("acc write in reset", '0, ofm_word_t'($sampled(DUT.acc_wr_ena)));

    a_valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        st_valid == st_ena_q)
        else report_mismatch("st_valid", ofm_word_t'($sampled(st_ena_q)),
                             ofm_word_t'($sampled(st_valid)));

    a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
        (st_valid && exp_chk) |-> st_data == exp_st)
        else report_mismatch("st_data", $sampled(exp_st), $sampled(st_data));

    // accumulator only writes while it owns the banks
    a_acc_owner: assert property (@(posedge clk) disable iff (!rst_n)
        DUT.acc_wr_ena |-> computing_on_going)
        else report_failure("accumulator wrote a bank outside computing_on_going");

    task automatic tick();
        @(posedge clk);
        #2;  // drive off the edge
    endtask

    task automatic load_words(int n);
        for (int i = 0; i < n; i++) begin
            ld_ena         = 1'b1;
            ld_data        = next_rand(DW);
            model[ld_pos]  = ld_data;
            known[ld_pos]  = 1'b1;
            ld_pos         = (ld_pos == pos_t'(TILE_WORDS - 1)) ? '0 : ld_pos + 1'b1;
            tick();
        end
        ld_ena = 1'b0;
        tick();  // last word still in the load register
    endtask

    task automatic store_words(int n);
        int gap;
        int waited = 0;
        for (int i = 0; i < n; i++) begin
            st_ena = 1'b1;
            st_issued++;
            tick();
            st_ena = 1'b0;
            gap = next_rand(2);  // 0..3 idle cycles
            repeat (gap) tick();
        end
        while (st_returned != st_issued) begin
            tick();
            waited++;
            if (waited > 4)
                report_failure("timeout waiting for st_valid after the last store strobe");
        end
    endtask

    task automatic send_psum(ofm_addr_t addr);
        pos_t idx;
        psum_valid = 1'b1;
        psum_addr  = addr;
        for (int b = 0; b < Y_BANKS; b++) begin
            psum_data[BSW'(b)] = next_rand(DW);
            idx = pos_t'(b * BANK_DEPTH + int'(addr));  // lane b lands in bank b
            model[idx] = model[idx] + psum_data[BSW'(b)];
        end
        tick();
    endtask

    task automatic drain_accumulator();
        int waited = 0;
        psum_valid = 1'b0;
        while (DUT.u_acc.s1_vld || DUT.acc_wr_ena) begin
            tick();
            waited++;
            if (waited > 2 * ACC_LATENCY)
                report_failure("timeout waiting for the accumulator pipeline to empty");
        end
        computing_on_going = 1'b0;
        tick();
    endtask

    initial begin
        logic [31:0] base;
        ofm_addr_t   a;
        int          waited;
        ld_ena             = 1'b0;
        ld_data            = '0;
        st_ena             = 1'b0;
        computing_on_going = 1'b0;
        psum_valid         = 1'b0;
        psum_addr          = '0;
        psum_data          = '0;
        foreach (known[i])
            known[i] = 1'b0;
        waited = 0;
        while (!rst_n) begin
            @(posedge clk);
            waited++;
            if (waited > 10)
                report_failure("timeout waiting for reset release");
        end
        tick();

        store_words(1);               // before any load, timing only
        store_words(TILE_WORDS - 1);  // back to position zero

        test_name = "round_trip";
        load_words(TILE_WORDS);
        store_words(TILE_WORDS);

        test_name = "accumulate";
        load_words(TILE_WORDS);
        computing_on_going = 1'b1;
        base = next_rand(AW);
        for (int i = 0; i < 16; i++) begin
            send_psum(ofm_addr_t'(base + 32'(i * 11)));  // odd stride, distinct
            if (next_rand(1) != 0) begin
                psum_valid = 1'b0;
                tick();
            end
        end
        drain_accumulator();
        psum_valid = 1'b1;            // stray vector, banks belong to the outer side
        psum_data  = {Y_BANKS{next_rand(DW)}};
        repeat (2) tick();
        psum_valid = 1'b0;
        store_words(TILE_WORDS);

        test_name = "forwarding";
        load_words(TILE_WORDS);
        computing_on_going = 1'b1;
        a = ofm_addr_t'(next_rand(AW));
        repeat (2) send_psum(a);
        a = a + 3'd5;
        repeat (3) send_psum(a);
        a = a + 3'd5;
        repeat (5) send_psum(a);
        a = a + 3'd5;
        send_psum(a);                  // a, b, a
        send_psum(a + 1'b1);
        send_psum(a);
        drain_accumulator();
        store_words(TILE_WORDS);

        test_name = "wrap";            // counters start their next pass at zero
        load_words(TILE_WORDS);
        store_words(TILE_WORDS);

        if (n_checked == 4 * TILE_WORDS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_failure($sformatf("only %0d store words were checked", n_checked));
        end
    end

endmodule

/* files.f */
rtl/cnn_tile_pkg.sv
rtl/ofm_data_pkg.sv
rtl/seq_counter.sv
rtl/dp_ram.sv
rtl/output_fm_bank.sv
rtl/ofm_stream_ctrl.sv
rtl/psum_accumulator.sv
rtl/output_fm_buffer.sv
verification/tb_clock_gen.sv
verification/output_fm_buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module output_fm_buffer_tb \
    -o output_fm_buffer_sim \
    && ./obj_dir/output_fm_buffer_sim | tee /dev/stderr \
        | grep -q "Simulation finished: PASS" \
    && exit 0 || exit 1
